//--- source/sgmii_pkg.sv
`default_nettype none

package sgmii_pkg;

	//////////////////////////////
	// Character and codeword types

	// One data or control character
	typedef logic [7:0] byte_t;

	// One 8b/10b codeword with bit 9 sent first
	// Bit order is {a,b,c,d,e,i,f,g,h,j}
	typedef logic [9:0] symbol_t;

	// The comma character and its two line forms
	localparam byte_t K28_5 = 8'hBC;
	localparam symbol_t K28_5_NEG = 10'b0011111010;
	localparam symbol_t K28_5_POS = 10'b1100000101;

	// 6b part shared by every K28.y when sent at negative disparity
	localparam logic [5:0] K28_6B = K28_5_NEG[9:4];

	// Alternate D.x.7 sub-blocks
	localparam logic [3:0] A7_NEG = 4'b0111;
	localparam logic [3:0] A7_POS = 4'b1000;

	//////////////////////////////
	// Link sync thresholds

	localparam int SYNC_COMMAS = 4;
	localparam int SYNC_HUNT_LIMIT = 12;
	localparam int SYNC_ERR_LIMIT = 4;

	typedef enum logic [1:0] {
		SYNC_HUNT,
		SYNC_SLIP_WAIT,
		SYNC_ACQUIRE,
		SYNC_LOCKED
	} sync_state_t;

	//////////////////////////////
	// Code tables

	// 5b/6b data table, form sent at negative disparity
	function automatic logic [5:0] code6_neg(input logic [4:0] x);
		logic [5:0] c;
		case (x)
			5'd0: c = 6'b100111;
			5'd1: c = 6'b011101;
			5'd2: c = 6'b101101;
			5'd3: c = 6'b110001;
			5'd4: c = 6'b110101;
			5'd5: c = 6'b101001;
			5'd6: c = 6'b011001;
			5'd7: c = 6'b111000;
			5'd8: c = 6'b111001;
			5'd9: c = 6'b100101;
			5'd10: c = 6'b010101;
			5'd11: c = 6'b110100;
			5'd12: c = 6'b001101;
			5'd13: c = 6'b101100;
			5'd14: c = 6'b011100;
			5'd15: c = 6'b010111;
			5'd16: c = 6'b011011;
			5'd17: c = 6'b100011;
			5'd18: c = 6'b010011;
			5'd19: c = 6'b110010;
			5'd20: c = 6'b001011;
			5'd21: c = 6'b101010;
			5'd22: c = 6'b011010;
			5'd23: c = 6'b111010;
			5'd24: c = 6'b110011;
			5'd25: c = 6'b100110;
			5'd26: c = 6'b010110;
			5'd27: c = 6'b110110;
			5'd28: c = 6'b001110;
			5'd29: c = 6'b101110;
			5'd30: c = 6'b011110;
			default: c = 6'b101011;
		endcase
		return c;
	endfunction

	// Positive form flips unbalanced codes and D.7
	function automatic logic [5:0] code6_pos(input logic [4:0] x);
		logic [5:0] n;
		n = code6_neg(x);
		return (($countones(n) != 3) || (x == 5'd7)) ? ~n : n;
	endfunction

	// 3b/4b data table, primary D.x.7 form, negative disparity
	function automatic logic [3:0] code4_neg(input logic [2:0] y);
		logic [3:0] c;
		case (y)
			3'd0: c = 4'b1011;
			3'd1: c = 4'b1001;
			3'd2: c = 4'b0101;
			3'd3: c = 4'b1100;
			3'd4: c = 4'b1101;
			3'd5: c = 4'b1010;
			3'd6: c = 4'b0110;
			default: c = 4'b1110;
		endcase
		return c;
	endfunction

	// Unbalanced codes and D.x.3 alternate
	function automatic logic [3:0] code4_pos(input logic [2:0] y);
		logic [3:0] n;
		n = code4_neg(y);
		return (($countones(n) != 2) || (y == 3'd3)) ? ~n : n;
	endfunction

endpackage

`default_nettype wire

//--- source/encode_8b10b.sv
`default_nettype none

module encode_8b10b import sgmii_pkg::*; (
	input wire symbol_clk,
	input wire reset,
	input wire take,
	input wire byte_t data,
	input wire is_ctl,
	output symbol_t codeword
);

	// Running disparity, high when positive
	logic rd_pos;

	logic [4:0] x;
	logic [2:0] y;
	logic [5:0] abcdei;
	logic [3:0] fghj;
	logic [3:0] k_fghj;
	logic rd_mid;
	logic rd_next;
	logic use_a7;

	//////////////////////////////
	// Sub-block selection

	always_comb begin
		x = data[4:0];
		y = data[7:5];

		// Only the K28 column is sent as control
		if (is_ctl)
			abcdei = rd_pos ? ~K28_6B : K28_6B;
		else
			abcdei = rd_pos ? code6_pos(x) : code6_neg(x);

		// Balanced 6b blocks leave the disparity alone
		rd_mid = rd_pos;
		if ($countones(abcdei) > 3)
			rd_mid = 1'b1;
		else if ($countones(abcdei) < 3)
			rd_mid = 1'b0;

		// A7 avoids a run of five equal bits across the sub-block edge
		use_a7 = (y == 3'd7) && (rd_mid ?
			(x == 5'd11 || x == 5'd13 || x == 5'd14) :
			(x == 5'd17 || x == 5'd18 || x == 5'd20));

		// K28 keeps the comma unique by inverting the positive form
		k_fghj = (y == 3'd7) ? A7_POS : code4_pos(y);

		if (is_ctl)
			fghj = rd_mid ? k_fghj : ~k_fghj;
		else if (use_a7)
			fghj = rd_mid ? A7_POS : A7_NEG;
		else
			fghj = rd_mid ? code4_pos(y) : code4_neg(y);

		rd_next = rd_mid;
		if ($countones(fghj) > 2)
			rd_next = 1'b1;
		else if ($countones(fghj) < 2)
			rd_next = 1'b0;

		codeword = {abcdei, fghj};
	end

	// Disparity moves only when the gearbox takes the codeword
	always_ff @(posedge symbol_clk) begin
		if (reset)
			rd_pos <= 1'b0;
		else if (take)
			rd_pos <= rd_next;
	end

endmodule

`default_nettype wire

//--- source/decode_8b10b.sv
`default_nettype none

module decode_8b10b import sgmii_pkg::*; (
	input wire symbol_clk,
	input wire reset,
	input wire sym_valid,
	input wire symbol_t sym,
	output logic rx_valid,
	output byte_t rx_data,
	output logic rx_is_ctl,
	output logic comma_seen,
	output logic code_err,
	output logic disp_err
);

	// Running disparity seen on the line
	logic rd_pos;

	logic [5:0] s6;
	logic [3:0] s4;
	logic [4:0] dx;
	logic [2:0] dy;
	logic [3:0] kf;
	logic is_k;
	logic ok6;
	logic ok4;
	logic rd_mid;
	logic rd_end;
	logic derr;

	//////////////////////////////
	// Reverse table lookup

	always_comb begin
		s6 = sym[9:4];
		s4 = sym[3:0];
		is_k = (s6 == K28_6B) || (s6 == ~K28_6B);

		// 6b sub-block, either polarity accepted here
		dx = 5'd28;
		ok6 = is_k;
		for (int i = 0; i < 32; i++) begin
			if (s6 == code6_neg(5'(i)) || s6 == code6_pos(5'(i))) begin
				dx = 5'(i);
				ok6 = 1'b1;
			end
		end

		// 4b sub-block
		dy = 3'd0;
		ok4 = 1'b0;
		kf = 4'b0000;
		for (int j = 0; j < 8; j++) begin
			if (is_k) begin
				kf = (j == 7) ? A7_POS : code4_pos(3'(j));
				if ((s6 == K28_6B) ? (s4 == kf) : (s4 == ~kf)) begin
					dy = 3'(j);
					ok4 = 1'b1;
				end
			end
			else if (s4 == code4_neg(3'(j)) || s4 == code4_pos(3'(j))) begin
				dy = 3'(j);
				ok4 = 1'b1;
			end
		end
		if (!is_k && (s4 == A7_NEG || s4 == A7_POS)) begin
			dy = 3'd7;
			ok4 = 1'b1;
		end

		// Disparity check per sub-block
		// 000111 and 0011 count as positive, 111000 and 1100 as negative
		derr = 1'b0;
		if (rd_pos ? ($countones(s6) > 3 || s6 == 6'b111000) :
			($countones(s6) < 3 || s6 == 6'b000111))
			derr = 1'b1;
		rd_mid = rd_pos;
		if ($countones(s6) > 3 || s6 == 6'b000111)
			rd_mid = 1'b1;
		else if ($countones(s6) < 3 || s6 == 6'b111000)
			rd_mid = 1'b0;

		if (rd_mid ? ($countones(s4) > 2 || s4 == 4'b1100) :
			($countones(s4) < 2 || s4 == 4'b0011))
			derr = 1'b1;
		rd_end = rd_mid;
		if ($countones(s4) > 2 || s4 == 4'b0011)
			rd_end = 1'b1;
		else if ($countones(s4) < 2 || s4 == 4'b1100)
			rd_end = 1'b0;
	end

	//////////////////////////////
	// Output registers

	always_ff @(posedge symbol_clk) begin
		if (reset) begin
			rx_valid <= 1'b0;
			comma_seen <= 1'b0;
			code_err <= 1'b0;
			disp_err <= 1'b0;
			rd_pos <= 1'b0;
		end
		else begin
			rx_valid <= sym_valid;
			comma_seen <= sym_valid && (sym == K28_5_NEG || sym == K28_5_POS);
			code_err <= sym_valid && !(ok6 && ok4);
			disp_err <= sym_valid && derr;
			// Keep tracking even through bad symbols
			if (sym_valid)
				rd_pos <= rd_end;
		end
	end

	always_ff @(posedge symbol_clk) begin
		if (sym_valid) begin
			rx_data <= {dy, dx};
			rx_is_ctl <= is_k;
		end
	end

endmodule

`default_nettype wire

//--- source/gearbox_8to10.sv
`default_nettype none

module gearbox_8to10 import sgmii_pkg::*; (
	input wire symbol_clk,
	input wire reset,
	input wire byte_t din,
	input wire bitslip,
	output logic sym_valid,
	output symbol_t sym
);

	// Received bits, oldest in the MSB
	logic [17:0] sbuf;

	// Number of valid bits in sbuf
	logic [4:0] fill;

	// Bits left after this cycle's symbol leaves
	logic [4:0] base;

	// A full symbol sits at the top of the buffer
	assign sym_valid = fill >= 5'd10;
	assign sym = sbuf[17:8];

	always_comb begin
		base = sym_valid ? fill - 5'd10 : fill;
	end

	// Bitslip drops the last bit of the incoming byte
	always_ff @(posedge symbol_clk) begin
		if (reset)
			fill <= 5'd0;
		else
			fill <= base + 5'd8 - {4'b0000, bitslip};
	end

	// Shift out the symbol, then place the new byte just after the held bits
	always_ff @(posedge symbol_clk) begin
		sbuf <= ((sym_valid ? sbuf << 10 : sbuf) & ~(18'h3FFFF >> base)) |
			({din, 10'b0} >> base);
	end

endmodule

`default_nettype wire

//--- source/gearbox_10to8.sv
`default_nettype none

module gearbox_10to8 import sgmii_pkg::*; (
	input wire symbol_clk,
	input wire reset,
	output logic take,
	input wire symbol_t codeword,
	output byte_t dout
);

	// Bits waiting to go out, oldest in the MSB
	logic [7:0] hold;

	// Count of valid bits in hold, 0 to 8
	logic [3:0] fill;

	// Held bits followed by the codeword taken this cycle
	logic [17:0] comb;

	// Without 8 held bits the next byte needs a new codeword
	// Fill runs 0,2,4,6,8 so take is high 4 cycles in 5
	assign take = fill < 4'd8;

	always_comb begin
		comb = ({hold, 10'b0} & ~(18'h3FFFF >> fill)) |
			(take ? ({8'b0, codeword} << (4'd8 - fill)) : 18'b0);
	end

	always_ff @(posedge symbol_clk) begin
		if (reset) begin
			fill <= 4'd0;
			dout <= '0;
		end
		else begin
			fill <= take ? fill + 4'd2 : fill - 4'd8;
			dout <= comb[17:10];
		end
	end

	// Leftover bits for the next cycle
	always_ff @(posedge symbol_clk) begin
		hold <= comb[9:2];
	end

endmodule

`default_nettype wire

//--- source/symbol_sync.sv
`default_nettype none

module symbol_sync import sgmii_pkg::*; (
	input wire symbol_clk,
	input wire reset,
	input wire sym_valid,
	input wire comma_seen,
	input wire code_err,
	output logic bitslip,
	output logic locked
);

	sync_state_t state;

	// Symbols since the last comma while hunting
	logic [3:0] hunt_cnt;

	// Aligned commas in acquire
	logic [2:0] comma_cnt;

	// Code errors since the last comma while locked
	logic [2:0] err_cnt;

	// One step done in slip wait
	logic wait_cnt;

	// Position parity in acquire, commas belong on even steps
	logic odd;

	assign locked = state == SYNC_LOCKED;

	always_ff @(posedge symbol_clk) begin
		if (reset) begin
			state <= SYNC_HUNT;
			hunt_cnt <= 4'd0;
			comma_cnt <= 3'd0;
			err_cnt <= 3'd0;
			wait_cnt <= 1'b0;
			odd <= 1'b0;
			bitslip <= 1'b0;
		end
		else begin
			bitslip <= 1'b0;

			if (sym_valid) begin
				case (state)

					// Look for any comma, slip after too long without one
					SYNC_HUNT: begin
						if (comma_seen) begin
							state <= SYNC_ACQUIRE;
							comma_cnt <= 3'd1;
							odd <= 1'b1;
							hunt_cnt <= 4'd0;
						end
						else if (hunt_cnt == 4'(SYNC_HUNT_LIMIT - 1)) begin
							state <= SYNC_SLIP_WAIT;
							bitslip <= 1'b1;
							wait_cnt <= 1'b0;
							hunt_cnt <= 4'd0;
						end
						else
							hunt_cnt <= hunt_cnt + 4'd1;
					end

					// Let symbols from before the slip drain out
					SYNC_SLIP_WAIT: begin
						wait_cnt <= ~wait_cnt;
						if (wait_cnt)
							state <= SYNC_HUNT;
					end

					SYNC_ACQUIRE: begin
						odd <= ~odd;
						if (!odd) begin
							if (!comma_seen)
								state <= SYNC_HUNT;
							else if (comma_cnt == 3'(SYNC_COMMAS - 1)) begin
								state <= SYNC_LOCKED;
								err_cnt <= 3'd0;
							end
							else
								comma_cnt <= comma_cnt + 3'd1;
						end
					end

					// Any comma forgives earlier errors
					SYNC_LOCKED: begin
						if (comma_seen)
							err_cnt <= 3'd0;
						else if (code_err) begin
							err_cnt <= err_cnt + 3'd1;
							if (err_cnt == 3'(SYNC_ERR_LIMIT - 1))
								state <= SYNC_HUNT;
						end
					end

					default: state <= SYNC_HUNT;

				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- source/sgmii_symbol_top.sv
`default_nettype none

module sgmii_symbol_top import sgmii_pkg::*; (
	input wire symbol_clk,
	input wire reset,
	input wire byte_t tx_data,
	input wire tx_is_ctl,
	output logic tx_take,
	output byte_t tx_byte,
	input wire byte_t rx_byte,
	output logic rx_valid,
	output byte_t rx_data,
	output logic rx_is_ctl,
	output logic rx_code_err,
	output logic rx_disp_err,
	output logic link_locked
);

	//////////////////////////////
	// Transmit path

	symbol_t tx_codeword;

	encode_8b10b encode_8b10b_inst (
		.symbol_clk(symbol_clk),
		.reset(reset),
		.take(tx_take),
		.data(tx_data),
		.is_ctl(tx_is_ctl),
		.codeword(tx_codeword)
	);

	// Pulls a codeword 4 cycles in 5
	gearbox_10to8 gearbox_10to8_inst (
		.symbol_clk(symbol_clk),
		.reset(reset),
		.take(tx_take),
		.codeword(tx_codeword),
		.dout(tx_byte)
	);

	//////////////////////////////
	// Receive path

	logic rx_sym_valid;
	symbol_t rx_sym;
	logic bitslip;
	logic comma_seen;

	gearbox_8to10 gearbox_8to10_inst (
		.symbol_clk(symbol_clk),
		.reset(reset),
		.din(rx_byte),
		.bitslip(bitslip),
		.sym_valid(rx_sym_valid),
		.sym(rx_sym)
	);

	decode_8b10b decode_8b10b_inst (
		.symbol_clk(symbol_clk),
		.reset(reset),
		.sym_valid(rx_sym_valid),
		.sym(rx_sym),
		.rx_valid(rx_valid),
		.rx_data(rx_data),
		.rx_is_ctl(rx_is_ctl),
		.comma_seen(comma_seen),
		.code_err(rx_code_err),
		.disp_err(rx_disp_err)
	);

	// Steps on decoded symbols, not raw gearbox output
	symbol_sync symbol_sync_inst (
		.symbol_clk(symbol_clk),
		.reset(reset),
		.sym_valid(rx_valid),
		.comma_seen(comma_seen),
		.code_err(rx_code_err),
		.bitslip(bitslip),
		.locked(link_locked)
	);

endmodule

`default_nettype wire

//--- dv/sgmii_symbol_chk.sv
`default_nettype none

module sgmii_symbol_chk (
	input wire symbol_clk,
	input wire reset,
	input wire tx_take,
	input wire [7:0] tx_byte,
	input wire rx_valid,
	input wire rx_code_err,
	input wire rx_disp_err,
	input wire bitslip,
	input wire link_locked
);

	// Length of the current run of high cycles
	logic [2:0] take_run;
	logic [2:0] valid_run;

	always @(posedge symbol_clk) begin
		if (reset) begin
			take_run <= 3'd0;
			valid_run <= 3'd0;
		end
		else begin
			take_run <= tx_take ? take_run + 3'd1 : 3'd0;
			valid_run <= rx_valid ? valid_run + 3'd1 : 3'd0;
		end
	end

	// No slipping on a locked link
	a_no_slip_locked: assert property (@(posedge symbol_clk) disable iff (reset)
		!(bitslip && link_locked)) else $error("bitslip while link locked");

	a_take_gap: assert property (@(posedge symbol_clk) disable iff (reset)
		!(tx_take && take_run == 3'd4)) else $error("tx_take high 5 cycles in a row");

	a_valid_gap: assert property (@(posedge symbol_clk) disable iff (reset)
		!(rx_valid && valid_run == 3'd4)) else $error("rx_valid high 5 cycles in a row");

	// From the second reset cycle on everything is quiet
	a_reset_quiet: assert property (@(posedge symbol_clk)
		(reset && $past(reset)) |-> (!link_locked && !bitslip && !rx_valid &&
		!rx_code_err && !rx_disp_err && tx_byte == 8'h00))
		else $error("output active during reset");

endmodule

`default_nettype wire

//--- dv/sgmii_symbol_tb.sv
`default_nettype none

module sgmii_symbol_tb import sgmii_pkg::*; ();

	localparam int MAX_TESTS = 32;

	logic symbol_clk;
	logic reset;
	byte_t tx_data;
	logic tx_is_ctl;
	logic tx_take;
	byte_t tx_byte;
	byte_t rx_byte;
	logic rx_valid;
	byte_t rx_data;
	logic rx_is_ctl;
	logic rx_code_err;
	logic rx_disp_err;
	logic link_locked;

	// Test table from the data file
	string t_name [MAX_TESTS];
	int t_offset [MAX_TESTS];
	int t_len [MAX_TESTS];
	int t_err [MAX_TESTS];
	int t_loss [MAX_TESTS];
	int num_tests;

	// Loopback line and error injection
	int offset;
	logic [15:0] hist;
	byte_t flip_a;
	byte_t flip_b;
	int tb_fill;

	// Transmit source mode with 0 for commas and 1 for payload
	int mode;
	int pay_idx;
	int pay_len;
	int err_at;
	int err_span;
	int trail;
	logic [15:0] lfsr;

	// Receive side bookkeeping
	byte_t exp_data [$];
	logic exp_ctl [$];
	string cur_name;
	bit cur_clean;
	bit had_lock;
	bit fell;
	bit err_seen;
	bit started;
	int rx_count;

	int errors;
	int checks;
	int cycles;
	int limit;
	bit loaded;

	sgmii_symbol_top sgmii_symbol_top_inst (
		.symbol_clk(symbol_clk),
		.reset(reset),
		.tx_data(tx_data),
		.tx_is_ctl(tx_is_ctl),
		.tx_take(tx_take),
		.tx_byte(tx_byte),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid),
		.rx_data(rx_data),
		.rx_is_ctl(rx_is_ctl),
		.rx_code_err(rx_code_err),
		.rx_disp_err(rx_disp_err),
		.link_locked(link_locked)
	);

	bind sgmii_symbol_top sgmii_symbol_chk chk_inst (
		.symbol_clk(symbol_clk),
		.reset(reset),
		.tx_take(tx_take),
		.tx_byte(tx_byte),
		.rx_valid(rx_valid),
		.rx_code_err(rx_code_err),
		.rx_disp_err(rx_disp_err),
		.bitslip(bitslip),
		.link_locked(link_locked)
	);

	initial begin
		symbol_clk = 1'b0;
		forever #4 symbol_clk = ~symbol_clk;
	end

	//////////////////////////////
	// Watchdog

	always @(posedge symbol_clk)
		cycles <= cycles + 1;

	initial begin
		wait (limit > 0 && cycles > limit);
		$display("run timed out after %0d cycles without finishing the tests", cycles);
		$display("Test FAILED");
		$finish;
	end

	//////////////////////////////
	// Compare tasks

	task automatic check_byte(input string name, input string what, input byte_t exp,
		input byte_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERR %0s %0s expected 0x%02h actual 0x%02h", name, what, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input string what, input logic exp,
		input logic act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERR %0s %0s expected %0b actual %0b", name, what, exp, act);
		end
	endtask

	//////////////////////////////
	// Payload source

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// 8 data bits then 1 control bit
	task automatic next_char(output byte_t d, output logic c);
		d = '0;
		for (int k = 0; k < 8; k++) begin
			lfsr = lfsr_step(lfsr);
			d = {d[6:0], lfsr[0]};
		end
		lfsr = lfsr_step(lfsr);
		c = lfsr[0];
	endtask

	//////////////////////////////
	// Per-cycle work at the falling edge

	task automatic drive();
		byte_t b;
		byte_t d;
		logic c;
		logic [15:0] sh;
		// Outputs are settled at the falling edge
		if (had_lock) begin
			if (!link_locked)
				fell = 1'b1;
			if (rx_code_err || rx_disp_err)
				err_seen = 1'b1;
			if (rx_valid) begin
				// Skip the commas ahead of the payload
				if (!started && !(rx_is_ctl && rx_data == K28_5))
					started = 1'b1;
				if (started && rx_count < pay_len) begin
					if (cur_clean) begin
						check_byte(cur_name, "rx_data", exp_data.pop_front(), rx_data);
						check_flag(cur_name, "rx_is_ctl", exp_ctl.pop_front(), rx_is_ctl);
					end
					rx_count++;
				end
			end
		end

		// Loopback with a bit delay of offset
		b = tx_byte ^ flip_a;
		flip_a = flip_b;
		flip_b = '0;
		hist = {hist[7:0], b};
		sh = hist >> offset;
		rx_byte = sh[7:0];

		// Take pauses only while a full byte waits in the gearbox
		check_flag(cur_name, "tx_take", tb_fill != 8, tx_take);

		if (tx_take) begin
			if (mode == 1 && pay_idx < pay_len) begin
				next_char(d, c);
				if (pay_idx == 0)
					c = 1'b0;
				if (c)
					d = K28_5;
				// Corrupt a comma whose last codeword bit lands two bytes later
				if (pay_idx >= err_at && pay_idx < err_at + err_span) begin
					d = K28_5;
					c = 1'b1;
					flip_b = byte_t'(1 << (6 - tb_fill));
				end
				if (cur_clean) begin
					exp_data.push_back(d);
					exp_ctl.push_back(c);
				end
				pay_idx++;
			end
			else begin
				d = K28_5;
				c = 1'b1;
				if (mode == 1)
					trail++;
			end
			tx_data = d;
			tx_is_ctl = c;
		end

		// Held bits walk 0,2,4,6,8 from reset
		tb_fill = (tb_fill == 8) ? 0 : tb_fill + 2;
	endtask

	task automatic step();
		@(negedge symbol_clk);
		drive();
	endtask

	task automatic reset_dut();
		reset = 1'b1;
		repeat (5) @(negedge symbol_clk);
		reset = 1'b0;
		tb_fill = 0;
		hist = '0;
		flip_a = '0;
		flip_b = '0;
		drive();
	endtask

	//////////////////////////////
	// Test file and sequencing

	task automatic load_tests(output bit ok);
		int fd;
		int n;
		string line;
		string nm;
		int o;
		int l;
		int e;
		int x;
		num_tests = 0;
		fd = $fopen("dv/sgmii_tests.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd) && num_tests < MAX_TESTS) begin
				n = $fgets(line, fd);
				if (n > 0 && line.len() > 1 && line[0] != "#") begin
					if ($sscanf(line, "%s %d %d %d %d", nm, o, l, e, x) == 5) begin
						t_name[num_tests] = nm;
						t_offset[num_tests] = o;
						t_len[num_tests] = l;
						t_err[num_tests] = e;
						t_loss[num_tests] = x;
						num_tests++;
					end
				end
			end
			$fclose(fd);
		end
		ok = num_tests > 0;
	endtask

	task automatic run_test(input int i);
		int start_errors;
		cur_name = t_name[i];
		offset = t_offset[i];
		pay_len = t_len[i];
		err_at = t_err[i];
		cur_clean = err_at < 0;
		err_span = cur_clean ? 0 : (t_loss[i] != 0 ? SYNC_ERR_LIMIT : 1);
		exp_data.delete();
		exp_ctl.delete();
		mode = 0;
		pay_idx = 0;
		trail = 0;
		had_lock = 1'b0;
		fell = 1'b0;
		err_seen = 1'b0;
		started = 1'b0;
		rx_count = 0;
		start_errors = errors;

		reset_dut();
		// Commas until the link locks
		while (!link_locked)
			step();
		had_lock = 1'b1;
		mode = 1;

		if (cur_clean) begin
			while (rx_count < pay_len)
				step();
		end
		else begin
			// Trailing commas also let a dropped link recover
			while (pay_idx < pay_len || trail < 16 || !link_locked)
				step();
		end

		check_flag(cur_name, "lock lost", t_loss[i] != 0, fell);
		check_flag(cur_name, "error flag seen", !cur_clean, err_seen);
		$display("test %0s offset %0d: %0s", cur_name, offset,
			(errors == start_errors) ? "pass" : "fail");
	endtask

	initial begin
		int sum_len;
		reset = 1'b1;
		tx_data = '0;
		tx_is_ctl = 1'b0;
		rx_byte = '0;
		errors = 0;
		checks = 0;
		limit = 0;
		lfsr = 16'd20;
		offset = 0;
		pay_len = 0;

		load_tests(loaded);
		if (!loaded)
			$display("could not read any test from dv/sgmii_tests.txt");
		else begin
			sum_len = 0;
			for (int i = 0; i < num_tests; i++)
				sum_len += t_len[i];
			limit = 40 + 2 * sum_len + 200 * num_tests;
			for (int i = 0; i < num_tests; i++)
				run_test(i);
		end

		$display("%0d tests, %0d checks, %0d errors", num_tests, checks, errors);
		if (loaded && errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/sgmii_tests.txt
# name offset payload_len err_symbol lock_loss
# err_symbol is a payload index or -1 for none, lock_loss 1 corrupts 4 symbols in a row
lock_off0 0 64 -1 0
lock_off1 1 64 -1 0
lock_off2 2 64 -1 0
lock_off3 3 64 -1 0
lock_off4 4 64 -1 0
lock_off5 5 64 -1 0
lock_off6 6 64 -1 0
lock_off7 7 64 -1 0
single_off1 1 80 30 0
single_off4 4 80 11 0
single_off6 6 80 50 0
single_off0 0 80 62 0
loss_off2 2 240 60 1
loss_off5 5 240 100 1
loss_off7 7 240 40 1

//--- files.f
source/sgmii_pkg.sv
source/encode_8b10b.sv
source/decode_8b10b.sv
source/gearbox_8to10.sv
source/gearbox_10to8.sv
source/symbol_sync.sv
source/sgmii_symbol_top.sv
dv/sgmii_symbol_chk.sv
dv/sgmii_symbol_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= sgmii_symbol_tb
RTL_TOP ?= sgmii_symbol_top
FILELIST ?= files.f
BUILD ?= obj_dir
VFLAGS ?= --binary --timing --assert

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	$(BUILD)/V$(TOP) | tee /dev/stderr | grep -x "Test OK" > /dev/null

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)
